// File: busarbiter/bus_arbiter.sv
module bus_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  logic                bus_ack,
    input  bus_pkg::arb_vector  bus_req,
    output bus_pkg::arb_vector  bus_grant
);

    import bus_pkg::*;

    typedef enum logic {
        READY,
        BUSY
    } state_t;

    state_t    state;
    arb_vector prio_req;

    // The lowest index request wins.
    always_comb begin
        logic found;
        found    = 1'b0;
        prio_req = NO_GRANT;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (!found && bus_req[i]) begin
                prio_req[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= READY;
            bus_grant <= NO_GRANT;
        end else begin
            case (state)
                READY: begin
                    bus_grant <= prio_req;
                    if (|bus_req) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // The grant is held until the transfer has been acknowledged.
                    if (bus_ack) begin
                        bus_grant <= prio_req;
                        if (|bus_req) begin
                            state <= BUSY;
                        end else begin
                            state <= READY;
                        end
                    end
                end
                default: begin
                    state     <= READY;
                    bus_grant <= NO_GRANT;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        $onehot0(bus_grant));

    assert property (@(posedge clk) disable iff (reset)
        (bus_grant != NO_GRANT && !bus_ack) |=> $stable(bus_grant));

    // A new grant goes only to a requester with no higher priority request beside it.
    for (genvar i = 0; i < N_MASTERS; i++) begin : g_prio_check
        assert property (@(posedge clk) disable iff (reset)
            $rose(bus_grant[i]) |->
                ($past(bus_req[i]) &&
                 (($past(bus_req) & arb_vector'((1 << i) - 1)) == NO_GRANT)));
    end

endmodule

// File: common/bus_pkg.sv
package bus_pkg;

    // Bus dimensions.
    localparam int N_MASTERS = 3;
    localparam int ADDR_W    = 6;
    localparam int DATA_W    = 32;

    // Wait states the memory inserts before pready in the access phase.
    localparam int MEM_WAIT  = 2;

    // One bit per master, used for requests and grants.
    typedef logic [N_MASTERS-1:0] arb_vector;

    localparam arb_vector NO_GRANT = '0;

    // Command posted by a master. The valid bit is a one-cycle pulse.
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_cmd_t;

    // Response returned to one master. rdata is meaningful with done for reads.
    typedef struct packed {
        logic              done;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // APB signals driven by the requester.
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // APB signals driven by the slave.
    typedef struct packed {
        logic              pready;
        logic [DATA_W-1:0] prdata;
    } apb_rsp_t;

endpackage

// File: hdl/apb_memory.sv
module apb_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_pkg::apb_req_t    apb_req,
    output bus_pkg::apb_rsp_t    apb_rsp
);

    import bus_pkg::*;

    typedef logic [$clog2(MEM_WAIT + 1)-1:0] wait_cnt_t;

    logic [DATA_W-1:0] mem [2**ADDR_W];
    wait_cnt_t         wait_cnt;
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              access;
    logic              last_wait;
    logic              complete;

    assign access    = apb_req.psel && apb_req.penable;
    assign complete  = access && pready;
    assign last_wait = access && !pready && (wait_cnt == wait_cnt_t'(MEM_WAIT - 1));

    // Count the wait states, then hold pready for the completing cycle.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pready   <= 1'b0;
            wait_cnt <= '0;
        end else if (complete) begin
            pready   <= 1'b0;
            wait_cnt <= '0;
        end else if (last_wait) begin
            pready   <= 1'b1;
        end else if (access && !pready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (last_wait) begin
            prdata <= mem[apb_req.paddr];
        end
        if (complete && apb_req.pwrite) begin
            mem[apb_req.paddr] <= apb_req.pwdata;
        end
    end

    assign apb_rsp = '{pready: pready, prdata: prdata};

    // The requester must keep the access phase up while pready is pending.
    assert property (@(posedge clk) disable iff (reset)
        pready |-> access);

endmodule

// File: hdl/apb_requester.sv
module apb_requester (
    input  logic                          clk,
    input  logic                          reset,
    input  bus_pkg::bus_cmd_t             cmd,
    output bus_pkg::apb_req_t             apb_req,
    input  bus_pkg::apb_rsp_t             apb_rsp,
    output logic                          xfer_done,
    output logic [bus_pkg::DATA_W-1:0]    xfer_rdata,
    output logic                          bus_ack
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        ACK
    } state_t;

    state_t            state;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            psel    <= 1'b0;
            penable <= 1'b0;
            bus_ack <= 1'b0;
        end else begin
            bus_ack <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd.valid) begin
                        state <= SETUP;
                        psel  <= 1'b1;
                    end
                end
                SETUP: begin
                    state   <= ACCESS;
                    penable <= 1'b1;
                end
                ACCESS: begin
                    if (xfer_done) begin
                        state   <= ACK;
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        bus_ack <= 1'b1;
                    end
                end
                // The grant is still the old one here, so nothing is started.
                ACK: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd.valid) begin
            pwrite <= cmd.write;
            paddr  <= cmd.addr;
            pwdata <= cmd.wdata;
        end
    end

    assign apb_req = '{psel: psel, penable: penable, pwrite: pwrite,
                       paddr: paddr, pwdata: pwdata};

    assign xfer_done  = psel && penable && apb_rsp.pready;
    assign xfer_rdata = apb_rsp.prdata;

    assert property (@(posedge clk) disable iff (reset)
        (psel && !xfer_done) |=>
            (psel && penable && $stable(pwrite) && $stable(paddr) && $stable(pwdata)));

endmodule

// File: hdl/bus_port_mux.sv
module bus_port_mux (
    input  logic                          clk,
    input  logic                          reset,
    input  bus_pkg::bus_cmd_t             m_cmd [bus_pkg::N_MASTERS],
    output bus_pkg::bus_rsp_t             m_rsp [bus_pkg::N_MASTERS],
    output bus_pkg::arb_vector            bus_req,
    input  bus_pkg::arb_vector            bus_grant,
    output bus_pkg::bus_cmd_t             sel_cmd,
    input  logic                          xfer_done,
    input  logic [bus_pkg::DATA_W-1:0]    xfer_rdata
);

    import bus_pkg::*;

    arb_vector         pending;
    arb_vector         done_q;
    bus_cmd_t          slot    [N_MASTERS];
    logic [DATA_W-1:0] rdata_q [N_MASTERS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= NO_GRANT;
            done_q  <= NO_GRANT;
        end else begin
            for (int i = 0; i < N_MASTERS; i++) begin
                done_q[i] <= xfer_done && bus_grant[i];
                if (m_cmd[i].valid) begin
                    pending[i] <= 1'b1;
                end else if (xfer_done && bus_grant[i]) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N_MASTERS; i++) begin
            if (m_cmd[i].valid) begin
                slot[i] <= m_cmd[i];
            end
            if (xfer_done && bus_grant[i]) begin
                rdata_q[i] <= xfer_rdata;
            end
        end
    end

    // The grant is one-hot, so at most one slot is picked.
    always_comb begin
        sel_cmd = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (bus_grant[i]) begin
                sel_cmd = slot[i];
            end
        end
        sel_cmd.valid = |bus_grant;
    end

    assign bus_req = pending;

    for (genvar i = 0; i < N_MASTERS; i++) begin : g_rsp
        assign m_rsp[i] = '{done: done_q[i], rdata: rdata_q[i]};

        // A master waits for its done before posting again.
        assert property (@(posedge clk) disable iff (reset)
            m_cmd[i].valid |-> !pending[i]);
    end

    assert property (@(posedge clk) disable iff (reset)
        xfer_done |-> ($onehot(bus_grant) && ((bus_grant & pending) == bus_grant)));

endmodule

// File: hdl/shared_bus_top.sv
module shared_bus_top (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_pkg::bus_cmd_t    m_cmd [bus_pkg::N_MASTERS],
    output bus_pkg::bus_rsp_t    m_rsp [bus_pkg::N_MASTERS],
    output bus_pkg::arb_vector   bus_grant
);

    import bus_pkg::*;

    arb_vector         bus_req;
    logic              bus_ack;
    bus_cmd_t          sel_cmd;
    logic              xfer_done;
    logic [DATA_W-1:0] xfer_rdata;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;

    bus_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .bus_grant (bus_grant)
    );

    bus_port_mux u_port_mux (
        .clk        (clk),
        .reset      (reset),
        .m_cmd      (m_cmd),
        .m_rsp      (m_rsp),
        .bus_req    (bus_req),
        .bus_grant  (bus_grant),
        .sel_cmd    (sel_cmd),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata)
    );

    apb_requester u_requester (
        .clk        (clk),
        .reset      (reset),
        .cmd        (sel_cmd),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata),
        .bus_ack    (bus_ack)
    );

    apb_memory u_memory (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the shared bus testbench with Verilator, runs it and scans the log.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module shared_bus_tb -f vlog.f -o shared_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/shared_bus_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* FAIL \*\*$' "$log"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tests/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);

    localparam time PERIOD       = 40;
    localparam int  RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset falls on a falling edge, after four rising edges have seen it high.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tests/shared_bus_tb.sv
module shared_bus_tb;

    import bus_pkg::*;

    localparam int  N_RANDOM   = 20;
    localparam int  N_TXN      = 10 + 2**ADDR_W + N_MASTERS * N_RANDOM;
    localparam time CLK_PERIOD = 40;

    logic              clk;
    logic              reset;
    bus_cmd_t          m_cmd      [N_MASTERS];
    bus_rsp_t          m_rsp      [N_MASTERS];
    arb_vector         bus_grant;

    logic [DATA_W-1:0] ref_mem    [2**ADDR_W];
    bus_cmd_t          pend_cmd   [N_MASTERS];
    time               post_time  [N_MASTERS];
    int                posted     [N_MASTERS];
    int                completed  [N_MASTERS] = '{default: 0};
    logic [DATA_W-1:0] last_rdata [N_MASTERS];
    bus_cmd_t          rand_cmd   [N_MASTERS][N_RANDOM];
    int                done_order [$];
    arb_vector         prev_grant     = NO_GRANT;
    logic              grant_finished = 1'b1;
    int                seed;
    int                errors       = 0;
    int                checks       = 0;
    int                test_errors  = 0;
    int                tests_failed = 0;
    int                test_num     = 0;
    string             test_name    = "startup";

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    shared_bus_top UUT (
        .clk       (clk),
        .reset     (reset),
        .m_cmd     (m_cmd),
        .m_rsp     (m_rsp),
        .bus_grant (bus_grant)
    );

    // A read returns the last value written to its address.
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        return ref_mem[addr];
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input int addr);
        return DATA_W'(32'hc0de_0000) | DATA_W'(addr * 257);
    endfunction

    function automatic logic outstanding(input int m);
        return posted[m] != completed[m];
    endfunction

    task automatic check_equal(input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected, input string what);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %0t: %s: got %h, expected %h", $time, what, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic post_cmd(input int m, input logic is_write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
        @(negedge clk);
        pend_cmd[m]  = '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata};
        post_time[m] = $time;
        posted[m]++;
        m_cmd[m]     = pend_cmd[m];
        @(negedge clk);
        m_cmd[m].valid = 1'b0;
    endtask

    task automatic wait_done(input int m);
        do begin
            @(posedge clk);
        end while (outstanding(m));
    endtask

    task automatic run_random(input int m);
        for (int n = 0; n < N_RANDOM; n++) begin
            post_cmd(m, rand_cmd[m][n].write, rand_cmd[m][n].addr, rand_cmd[m][n].wdata);
            wait_done(m);
        end
    endtask

    task automatic check_done_order(input int first, input int second, input int third);
        check_equal(DATA_W'(done_order.size()), DATA_W'(3), "number of done pulses");
        if (done_order.size() == 3) begin
            check_equal(DATA_W'(done_order[0]), DATA_W'(first), "first done");
            check_equal(DATA_W'(done_order[1]), DATA_W'(second), "second done");
            check_equal(DATA_W'(done_order[2]), DATA_W'(third), "third done");
        end
    endtask

    task automatic start_test(input int num, input string name);
        test_num    = num;
        test_name   = name;
        test_errors = 0;
        done_order.delete();
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %0d %s: passed", test_num, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, test_name, test_errors);
            tests_failed++;
        end
    endtask

    // Compare process. Dones update the reference model in bus order.
    always @(negedge clk) begin
        logic above;
        if (!reset) begin
            check_equal(DATA_W'($onehot0(bus_grant)), DATA_W'(1), "grant is one-hot or zero");
            if (bus_grant != prev_grant) begin
                if (prev_grant != NO_GRANT) begin
                    check_equal(DATA_W'(grant_finished), DATA_W'(1), "grant moved before done");
                end
                grant_finished = 1'b0;
                above          = 1'b1;
                for (int k = 0; k < N_MASTERS; k++) begin
                    if (bus_grant[k]) begin
                        above = 1'b0;
                    end else if (above && bus_grant != NO_GRANT && outstanding(k) &&
                                 post_time[k] + 2 * CLK_PERIOD <= $time) begin
                        // The arbiter saw this request when it made the new grant.
                        check_equal(DATA_W'(bus_grant), DATA_W'(1 << k), "grant priority");
                    end
                end
            end
            for (int m = 0; m < N_MASTERS; m++) begin
                if (m_rsp[m].done) begin
                    check_equal(DATA_W'(outstanding(m)), DATA_W'(1), "done without a command");
                    check_equal(DATA_W'(bus_grant[m]), DATA_W'(1), "done without the grant");
                    if (pend_cmd[m].write) begin
                        ref_mem[pend_cmd[m].addr] = pend_cmd[m].wdata;
                    end else begin
                        check_equal(m_rsp[m].rdata, expected_read(pend_cmd[m].addr), "read data");
                    end
                    last_rdata[m] = m_rsp[m].rdata;
                    completed[m]++;
                    done_order.push_back(m);
                    grant_finished = 1'b1;
                end
            end
            prev_grant = bus_grant;
        end
    end

    // Watchdog. Forty cycles per transaction is far above the worst bus latency.
    initial begin
        #((N_TXN * 40 + 10) * CLK_PERIOD);
        $display("Timeout: test %0d (%s) did not finish", test_num, test_name);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0]       r;
        logic [DATA_W-1:0] data;
        seed = 35905;
        for (int m = 0; m < N_MASTERS; m++) begin
            m_cmd[m]     = '0;
            posted[m]    = 0;
            post_time[m] = 0;
            for (int n = 0; n < N_RANDOM; n++) begin
                r = $random(seed);
                rand_cmd[m][n] = '{valid: 1'b1, write: r[0], addr: r[ADDR_W:1],
                                   wdata: $random(seed)};
            end
        end

        start_test(1, "reset state");
        @(negedge reset);
        repeat (6) begin
            @(negedge clk);
            check_equal(DATA_W'(bus_grant), DATA_W'(NO_GRANT), "grant after reset");
            for (int m = 0; m < N_MASTERS; m++) begin
                check_equal(DATA_W'(m_rsp[m].done), DATA_W'(0), "done after reset");
            end
        end
        end_test();

        start_test(2, "single master write and read");
        data = $random(seed);
        post_cmd(0, 1'b1, 6'h15, data);
        wait_done(0);
        post_cmd(0, 1'b0, 6'h15, '0);
        wait_done(0);
        check_equal(last_rdata[0], data, "read back on master 0");
        end_test();

        start_test(3, "simultaneous posts");
        fork
            post_cmd(0, 1'b1, 6'h08, 32'h0000_0a08);
            post_cmd(1, 1'b1, 6'h09, 32'h0000_0b09);
            post_cmd(2, 1'b1, 6'h0a, 32'h0000_0c0a);
        join
        for (int m = 0; m < N_MASTERS; m++) begin
            wait_done(m);
        end
        check_done_order(0, 1, 2);
        end_test();

        start_test(4, "grant held until done");
        post_cmd(1, 1'b0, 6'h09, '0);
        while (!bus_grant[1]) @(negedge clk);
        // Master 0 outranks master 1 but must wait for the running transfer.
        fork
            post_cmd(0, 1'b0, 6'h08, '0);
            post_cmd(2, 1'b1, 6'h0a, $random(seed));
        join
        for (int m = 0; m < N_MASTERS; m++) begin
            wait_done(m);
        end
        check_done_order(1, 0, 2);
        check_equal(last_rdata[1], 32'h0000_0b09, "read on master 1");
        check_equal(last_rdata[0], 32'h0000_0a08, "read on master 0");
        end_test();

        start_test(5, "master 2 alone");
        data = $random(seed);
        post_cmd(2, 1'b1, 6'h3f, data);
        wait_done(2);
        post_cmd(2, 1'b0, 6'h3f, '0);
        wait_done(2);
        check_equal(last_rdata[2], data, "read back on master 2");
        end_test();

        start_test(6, "random traffic from all masters");
        for (int a = 0; a < 2**ADDR_W; a++) begin
            post_cmd(a % N_MASTERS, 1'b1, ADDR_W'(a), fill_word(a));
            wait_done(a % N_MASTERS);
        end
        fork
            run_random(0);
            run_random(1);
            run_random(2);
        join
        end_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 test_num, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/bus_pkg.sv
busarbiter/bus_arbiter.sv
hdl/bus_port_mux.sv
hdl/apb_requester.sv
hdl/apb_memory.sv
hdl/shared_bus_top.sv
tests/clock_gen.sv
tests/shared_bus_tb.sv
